// ==== dv/eeprom_model.sv ====
`timescale 1ns/1ps

module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic ack_en,
    output logic sda_oe
);
    logic [7:0]  mem [0:2047];
    logic [7:0]  shift;
    logic [7:0]  out_byte;
    logic [3:0]  bit_cnt;      // rising edges seen in this byte
    logic [1:0]  byte_idx;     // 0 control, 1 word address, 2 data
    logic [10:0] ptr;
    logic        active;
    logic        rd_mode;
    logic        tx;           // model drives the data byte
    logic        ack_pending;
    integer      seed;
    integer      i;

    initial begin
        seed = 32'h7949;
        for (i = 0; i < 2048; i = i + 1)
            mem[i] = $random(seed);
        sda_oe      = 1'b0;
        active      = 1'b0;
        rd_mode     = 1'b0;
        tx          = 1'b0;
        ack_pending = 1'b0;
        bit_cnt     = 4'd0;
        byte_idx    = 2'd0;
        ptr         = 11'd0;
    end

    task automatic accept_byte();
        ack_pending = 1'b1;
        case (byte_idx)
            2'd0: begin
                if (shift[7:4] == 4'b1010 && ack_en) begin
                    ptr[10:8] = shift[3:1];  // block select
                    rd_mode   = shift[0];
                end else begin
                    ack_pending = 1'b0;     // stay silent until the next start
                    active      = 1'b0;
                end
            end
            2'd1: ptr[7:0] = shift;
            default: begin
                mem[ptr] = shift;
                ptr      = ptr + 11'd1;
            end
        endcase
        if (byte_idx != 2'd2)
            byte_idx = byte_idx + 2'd1;
    endtask

    // start or repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            active      = 1'b1;
            tx          = 1'b0;
            rd_mode     = 1'b0;
            ack_pending = 1'b0;
            bit_cnt     = 4'd0;
            byte_idx    = 2'd0;
        end
    end

    // stop
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            active = 1'b0;
            tx     = 1'b0;
            sda_oe = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (active) begin
            bit_cnt = bit_cnt + 4'd1;
            if (!tx && bit_cnt <= 4'd8)
                shift = {shift[6:0], sda};
            if (!tx && bit_cnt == 4'd8)
                accept_byte();
            if (bit_cnt == 4'd9) begin
                bit_cnt = 4'd0;
                if (tx) begin
                    if (sda) begin  // master nack ends the read
                        tx     = 1'b0;
                        active = 1'b0;
                    end else begin
                        ptr      = ptr + 11'd1;
                        out_byte = mem[ptr];
                    end
                end else if (ack_pending && rd_mode) begin
                    tx       = 1'b1;
                    out_byte = mem[ptr];
                end
                ack_pending = 1'b0;
            end
        end
    end

    always @(negedge scl) begin
        if (active) begin
            if (bit_cnt == 4'd8)
                sda_oe = ack_pending;
            else if (tx)
                sda_oe = !out_byte[3'd7 - bit_cnt[2:0]];  // msb first
            else
                sda_oe = 1'b0;
        end
    end

endmodule

// ==== dv/tb_eeprom.sv ====
`timescale 1ns/1ps

module tb_eeprom;

    typedef enum logic [2:0] {
        row_write,
        row_read,
        row_regs,
        row_noack,
        row_busy
    } row_kind_t;

    logic                  CLK;
    logic                  RESET;
    logic                  awvalid;
    logic                  awready;
    eeprom_pkg::reg_addr_t awaddr;
    logic                  wvalid;
    logic                  wready;
    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic                  bvalid;
    logic [1:0]            bresp;
    logic                  bready;
    logic                  arvalid;
    logic                  arready;
    eeprom_pkg::reg_addr_t araddr;
    logic                  rvalid;
    logic [31:0]           rdata;
    logic [1:0]            rresp;
    logic                  rready;
    logic                  scl;
    logic                  dut_sda_oe;
    logic                  model_sda_oe;
    logic                  model_ack;
    wire                   sda;

    logic [2:0]  kinds    [$];
    logic [10:0] addrs    [$];
    logic [7:0]  datas    [$];
    logic [2:0]  statuses [$];
    logic [7:0]  mirror   [0:2047];
    logic        table_ready;
    integer      done_count;
    integer      seed;
    integer      i;
    integer      r;

    assign sda = !(dut_sda_oe || model_sda_oe);  // pull-up, either side pulls low

    eeprom_top dut0 (
        .CLK     (CLK),
        .RESET   (RESET),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .bready  (bready),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rready  (rready),
        .scl     (scl),
        .sda_oe  (dut_sda_oe),
        .sda_in  (sda)
    );

    eeprom_model eeprom0 (
        .scl    (scl),
        .sda    (sda),
        .ack_en (model_ack),
        .sda_oe (model_sda_oe)
    );

    always #4 CLK = ~CLK;

    always @(posedge CLK) begin
        if (!RESET && dut0.done === 1'b1)
            done_count <= done_count + 1;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic axi_write(input eeprom_pkg::reg_addr_t addr, input logic [31:0] data,
                             output logic [1:0] resp);
        logic aw_pend;
        logic w_pend;
        logic aw_fire;
        logic w_fire;
        aw_pend = 1'b1;
        w_pend  = 1'b1;
        @(negedge CLK);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = 4'hF;
        while (aw_pend || w_pend) begin
            aw_fire = aw_pend && awready;  // taken on the coming rising edge
            w_fire  = w_pend && wready;
            @(negedge CLK);
            if (aw_fire) begin
                awvalid = 1'b0;
                aw_pend = 1'b0;
            end
            if (w_fire) begin
                wvalid = 1'b0;
                w_pend = 1'b0;
            end
        end
        bready = 1'b1;
        while (!bvalid)
            @(negedge CLK);
        resp = bresp;
        @(negedge CLK);
        bready = 1'b0;
    endtask

    task automatic axi_read(input eeprom_pkg::reg_addr_t addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge CLK);
        arvalid = 1'b1;
        araddr  = addr;
        while (!arready)
            @(negedge CLK);
        @(negedge CLK);
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid)
            @(negedge CLK);
        data = rdata;
        resp = rresp;
        @(negedge CLK);
        rready = 1'b0;
    endtask

    task automatic write_reg(input eeprom_pkg::reg_addr_t addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check_value("bresp", exp_resp, resp);
    endtask

    task automatic read_reg(input eeprom_pkg::reg_addr_t addr, input logic [1:0] exp_resp,
                            output logic [31:0] value);
        logic [1:0] resp;
        axi_read(addr, value, resp);
        check_value("rresp", exp_resp, resp);
    endtask

    task automatic wait_done(output logic [31:0] status);
        status = 32'd0;
        while (!status[1])
            read_reg(eeprom_pkg::reg_status, eeprom_pkg::resp_okay, status);
    endtask

    task automatic wait_busy();
        logic [31:0] status;
        status = 32'd0;
        while (!status[0])
            read_reg(eeprom_pkg::reg_status, eeprom_pkg::resp_okay, status);
    endtask

    task automatic add_row(input row_kind_t kind, input logic [10:0] addr,
                           input logic [7:0] data, input logic [2:0] status);
        kinds.push_back(kind);
        addrs.push_back(addr);
        datas.push_back(data);
        statuses.push_back(status);  // {nack, done, busy}
    endtask

    task automatic run_row(input integer n);
        logic [31:0] value;
        integer      dones;
        case (kinds[n])
            row_write, row_noack, row_busy: begin
                model_ack = kinds[n] != row_noack;
                write_reg(eeprom_pkg::reg_addr, {21'd0, addrs[n]}, eeprom_pkg::resp_okay);
                write_reg(eeprom_pkg::reg_wdata, {24'd0, datas[n]}, eeprom_pkg::resp_okay);
                dones = done_count;
                write_reg(eeprom_pkg::reg_cmd, 32'h1, eeprom_pkg::resp_okay);
                if (kinds[n] == row_busy) begin
                    wait_busy();
                    write_reg(eeprom_pkg::reg_cmd, 32'h2, eeprom_pkg::resp_okay);
                end
                wait_done(value);
                check_value("status", statuses[n], value);
                check_value("done pulses", dones + 1, done_count);
                if (!statuses[n][2])
                    mirror[addrs[n]] = datas[n];
                check_value("model mem", mirror[addrs[n]], eeprom0.mem[addrs[n]]);
                model_ack = 1'b1;
            end
            row_read: begin
                write_reg(eeprom_pkg::reg_addr, {21'd0, addrs[n]}, eeprom_pkg::resp_okay);
                write_reg(eeprom_pkg::reg_cmd, 32'h2, eeprom_pkg::resp_okay);
                wait_done(value);
                check_value("status", statuses[n], value);
                read_reg(eeprom_pkg::reg_rdata, eeprom_pkg::resp_okay, value);
                check_value("reg_rdata", {24'd0, mirror[addrs[n]]}, value);
            end
            default: begin
                write_reg(eeprom_pkg::reg_addr, {21'h1FFFFF, addrs[n]}, eeprom_pkg::resp_okay);
                read_reg(eeprom_pkg::reg_addr, eeprom_pkg::resp_okay, value);
                check_value("reg_addr", {21'd0, addrs[n]}, value);
                write_reg(eeprom_pkg::reg_wdata, {24'hFFFFFF, datas[n]}, eeprom_pkg::resp_okay);
                read_reg(eeprom_pkg::reg_wdata, eeprom_pkg::resp_okay, value);
                check_value("reg_wdata", {24'd0, datas[n]}, value);
                // 0x14 lies past the register map
                write_reg(5'h14, 32'hFFFF_FFFF, eeprom_pkg::resp_slverr);
                read_reg(5'h14, eeprom_pkg::resp_slverr, value);
                check_value("unmapped rdata", 32'd0, value);
            end
        endcase
    endtask

    initial begin
        CLK         = 1'b0;
        RESET       = 1'b1;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = 32'd0;
        wstrb       = 4'h0;
        bready      = 1'b0;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b0;
        model_ack   = 1'b1;
        done_count  = 0;
        table_ready = 1'b0;
        seed        = 32'h7949;
        for (i = 0; i < 2048; i = i + 1)
            mirror[i] = $random(seed);  // same sequence as the model's fill

        add_row(row_write, 11'h123, 8'h5A, 3'b010);
        add_row(row_read,  11'h123, 8'h00, 3'b010);
        add_row(row_read,  11'h011, 8'h00, 3'b010);  // one per 256-byte block
        add_row(row_read,  11'h1A2, 8'h00, 3'b010);
        add_row(row_read,  11'h233, 8'h00, 3'b010);
        add_row(row_read,  11'h3C4, 8'h00, 3'b010);
        add_row(row_read,  11'h455, 8'h00, 3'b010);
        add_row(row_read,  11'h5E6, 8'h00, 3'b010);
        add_row(row_read,  11'h677, 8'h00, 3'b010);
        add_row(row_read,  11'h7F8, 8'h00, 3'b010);
        add_row(row_write, 11'h7FF, 8'hC3, 3'b010);
        add_row(row_read,  11'h7FF, 8'h00, 3'b010);
        add_row(row_write, 11'h000, 8'h81, 3'b010);
        add_row(row_read,  11'h000, 8'h00, 3'b010);
        add_row(row_noack, 11'h345, 8'h99, 3'b110);
        add_row(row_read,  11'h345, 8'h00, 3'b010);
        add_row(row_regs,  11'h7AB, 8'hA5, 3'b000);
        add_row(row_busy,  11'h456, 8'h3C, 3'b010);
        add_row(row_read,  11'h456, 8'h00, 3'b010);
        add_row(row_regs,  11'h2C4, 8'h5E, 3'b000);
        table_ready = 1'b1;

        repeat (5) @(negedge CLK);
        RESET = 1'b0;

        for (r = 0; r < kinds.size(); r = r + 1)
            run_row(r);
        $display("ALL TESTS PASSED");
        $finish;
    end

    // 4 us per row covers a random read plus status polling
    initial begin
        wait (table_ready);
        #(kinds.size() * 4000 + 40);
        $display("run timed out before the last stimulus row finished");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== tb.f ====
verilog/eeprom_pkg.sv
verilog/eeprom_regs.sv
verilog/i2c_bit_engine.sv
verilog/eeprom_ctrl.sv
verilog/eeprom_top.sv
dv/eeprom_model.sv
dv/tb_eeprom.sv

// ==== verilog/eeprom_ctrl.sv ====
`timescale 1ns/1ps

module eeprom_ctrl (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_write,
    input  logic                 cmd_read,
    input  eeprom_pkg::ee_addr_t ee_addr,
    input  eeprom_pkg::ee_data_t ee_wdata,
    output logic                 busy,
    output logic                 done,
    output logic                 nack,
    output eeprom_pkg::ee_data_t rdata_out,
    output eeprom_pkg::bit_op_t  op,
    output eeprom_pkg::ee_data_t tx_byte,
    output logic                 op_valid,
    input  logic                 op_ready,
    input  eeprom_pkg::ee_data_t rx_byte,
    input  logic                 ack_seen
);
    eeprom_pkg::ctrl_state_t state;
    eeprom_pkg::ctrl_state_t next_ok;  // successor when the op went well
    eeprom_pkg::ee_addr_t    addr_q;
    eeprom_pkg::ee_data_t    wdata_q;
    logic                    read_q;
    logic                    issued;
    logic                    op_done;
    logic                    wants_ack;

    assign busy      = state != eeprom_pkg::idle;
    assign op_valid  = busy && !issued;
    assign op_done   = issued && op_ready;
    assign wants_ack = op == eeprom_pkg::op_send;

    always_comb begin
        op      = eeprom_pkg::op_stop;
        tx_byte = 8'h00;
        next_ok = eeprom_pkg::idle;
        case (state)
            eeprom_pkg::start: begin
                op      = eeprom_pkg::op_start;
                next_ok = eeprom_pkg::ctrl_w;
            end
            eeprom_pkg::ctrl_w: begin
                op      = eeprom_pkg::op_send;
                tx_byte = {eeprom_pkg::dev_type, addr_q[10:8], 1'b0}; // block bits in ctrl byte
                next_ok = eeprom_pkg::word_addr;
            end
            eeprom_pkg::word_addr: begin
                op      = eeprom_pkg::op_send;
                tx_byte = addr_q[7:0];
                next_ok = read_q ? eeprom_pkg::restart : eeprom_pkg::data_w;
            end
            eeprom_pkg::data_w: begin
                op      = eeprom_pkg::op_send;
                tx_byte = wdata_q;
                next_ok = eeprom_pkg::stop;
            end
            eeprom_pkg::restart: begin
                op      = eeprom_pkg::op_start;
                next_ok = eeprom_pkg::ctrl_r;
            end
            eeprom_pkg::ctrl_r: begin
                op      = eeprom_pkg::op_send;
                tx_byte = {eeprom_pkg::dev_type, addr_q[10:8], 1'b1};
                next_ok = eeprom_pkg::data_r;
            end
            eeprom_pkg::data_r: begin
                op      = eeprom_pkg::op_recv;
                tx_byte = 8'h01;  // single byte, end with nack
                next_ok = eeprom_pkg::stop;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state  <= eeprom_pkg::idle;
            issued <= 1'b0;
            done   <= 1'b0;
            nack   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state == eeprom_pkg::idle) begin
                if (cmd_write || cmd_read) begin
                    state <= eeprom_pkg::start;
                    nack  <= 1'b0;
                end
            end else if (op_valid && op_ready) begin
                issued <= 1'b1;
            end else if (op_done) begin
                issued <= 1'b0;
                if (wants_ack && !ack_seen) begin
                    state <= eeprom_pkg::stop;  // no ack, bail out
                    nack  <= 1'b1;
                end else begin
                    state <= next_ok;
                end
                if (state == eeprom_pkg::stop)
                    done <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == eeprom_pkg::idle && (cmd_write || cmd_read)) begin
            addr_q  <= ee_addr;
            wdata_q <= ee_wdata;
            read_q  <= cmd_read;
        end
        if (op_done && state == eeprom_pkg::data_r)
            rdata_out <= rx_byte;
    end

    assert property (@(posedge CLK) disable iff (RESET) op_valid |-> op_ready)
        else $error("op_valid raised while bit engine busy");

endmodule

// ==== verilog/eeprom_pkg.sv ====
package eeprom_pkg;

    typedef logic [10:0] ee_addr_t;
    typedef logic [7:0]  ee_data_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int scl_half = 4;              // CLK cycles per SCL half period
    localparam logic [3:0] dev_type = 4'b1010;

    // register map
    localparam reg_addr_t reg_cmd    = 5'h00; // bit 0 write, bit 1 read
    localparam reg_addr_t reg_addr   = 5'h04;
    localparam reg_addr_t reg_wdata  = 5'h08;
    localparam reg_addr_t reg_rdata  = 5'h0C;
    localparam reg_addr_t reg_status = 5'h10; // busy, done, nack

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef enum logic [1:0] {
        op_start,
        op_stop,
        op_send,
        op_recv
    } bit_op_t;

    typedef enum logic [3:0] {
        idle,
        start,
        ctrl_w,
        word_addr,
        data_w,
        restart,
        ctrl_r,
        data_r,
        stop
    } ctrl_state_t;

endpackage

// ==== verilog/eeprom_regs.sv ====
`timescale 1ns/1ps

module eeprom_regs (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  awvalid,
    output logic                  awready,
    input  eeprom_pkg::reg_addr_t awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    output logic                  bvalid,
    output logic [1:0]            bresp,
    input  logic                  bready,
    input  logic                  arvalid,
    output logic                  arready,
    input  eeprom_pkg::reg_addr_t araddr,
    output logic                  rvalid,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    input  logic                  rready,
    output logic                  cmd_write,
    output logic                  cmd_read,
    output eeprom_pkg::ee_addr_t  ee_addr,
    output eeprom_pkg::ee_data_t  ee_wdata,
    input  logic                  busy,
    input  logic                  done,
    input  logic                  nack,
    input  eeprom_pkg::ee_data_t  rdata_in
);
    logic                  aw_held;
    logic                  w_held;
    eeprom_pkg::reg_addr_t awaddr_q;
    logic [31:0]           wdata_q;
    logic [3:0]            wstrb_q;
    logic                  aw_take;
    logic                  w_take;
    logic                  wr_fire;
    eeprom_pkg::reg_addr_t wr_addr;
    logic [31:0]           wr_data;
    logic [3:0]            wr_strb;
    logic                  cmd_go;
    logic                  done_q;
    logic                  nack_q;
    logic [31:0]           rd_value;

    function automatic logic mapped(eeprom_pkg::reg_addr_t a);
        return a inside {eeprom_pkg::reg_cmd, eeprom_pkg::reg_addr, eeprom_pkg::reg_wdata,
                         eeprom_pkg::reg_rdata, eeprom_pkg::reg_status};
    endfunction

    // one outstanding response per side
    assign awready = !aw_held && !bvalid;
    assign wready  = !w_held && !bvalid;
    assign arready = !rvalid;

    assign aw_take = awvalid && awready;
    assign w_take  = wvalid && wready;
    assign wr_fire = (aw_take || aw_held) && (w_take || w_held);
    assign wr_addr = aw_held ? awaddr_q : awaddr;
    assign wr_data = w_held ? wdata_q : wdata;
    assign wr_strb = w_held ? wstrb_q : wstrb;

    // commands only land on an idle sequencer
    assign cmd_go = wr_fire && wr_addr == eeprom_pkg::reg_cmd && wr_strb[0] &&
                    |wr_data[1:0] && !busy && !cmd_write && !cmd_read;

    always_ff @(posedge CLK) begin
        if (aw_take)
            awaddr_q <= awaddr;
        if (w_take) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= eeprom_pkg::resp_okay;
        end else begin
            aw_held <= (aw_held || aw_take) && !wr_fire;
            w_held  <= (w_held || w_take) && !wr_fire;
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= mapped(wr_addr) ? eeprom_pkg::resp_okay : eeprom_pkg::resp_slverr;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            cmd_write <= 1'b0;
            cmd_read  <= 1'b0;
            done_q    <= 1'b0;
            nack_q    <= 1'b0;
            ee_addr   <= '0;
            ee_wdata  <= '0;
        end else begin
            cmd_write <= cmd_go && wr_data[0];
            cmd_read  <= cmd_go && wr_data[1] && !wr_data[0]; // write wins
            if (wr_fire && wr_addr == eeprom_pkg::reg_addr) begin
                if (wr_strb[0])
                    ee_addr[7:0] <= wr_data[7:0];
                if (wr_strb[1])
                    ee_addr[10:8] <= wr_data[10:8];
            end
            if (wr_fire && wr_addr == eeprom_pkg::reg_wdata && wr_strb[0])
                ee_wdata <= wr_data[7:0];
            if (cmd_go) begin
                done_q <= 1'b0;
                nack_q <= 1'b0;
            end else if (done) begin
                done_q <= 1'b1;  // sticky
                nack_q <= nack;
            end
        end
    end

    always_comb begin
        case (araddr)
            eeprom_pkg::reg_addr:   rd_value = {21'd0, ee_addr};
            eeprom_pkg::reg_wdata:  rd_value = {24'd0, ee_wdata};
            eeprom_pkg::reg_rdata:  rd_value = {24'd0, rdata_in};
            eeprom_pkg::reg_status: rd_value = {29'd0, nack_q, done_q, busy};
            default:                rd_value = 32'd0; // cmd self clears
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            rvalid <= 1'b0;
            rresp  <= eeprom_pkg::resp_okay;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
            rresp  <= mapped(araddr) ? eeprom_pkg::resp_okay : eeprom_pkg::resp_slverr;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (arvalid && arready)
            rdata <= rd_value;
    end

    assert property (@(posedge CLK) disable iff (RESET) !(cmd_write && cmd_read))
        else $error("cmd_write and cmd_read high together");

    assert property (@(posedge CLK) disable iff (RESET) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

endmodule

// ==== verilog/eeprom_top.sv ====
`timescale 1ns/1ps

module eeprom_top (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  awvalid,
    output logic                  awready,
    input  eeprom_pkg::reg_addr_t awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    output logic                  bvalid,
    output logic [1:0]            bresp,
    input  logic                  bready,
    input  logic                  arvalid,
    output logic                  arready,
    input  eeprom_pkg::reg_addr_t araddr,
    output logic                  rvalid,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    input  logic                  rready,
    output logic                  scl,
    output logic                  sda_oe,
    input  logic                  sda_in
);
    logic                 cmd_write;
    logic                 cmd_read;
    eeprom_pkg::ee_addr_t ee_addr;
    eeprom_pkg::ee_data_t ee_wdata;
    logic                 busy;
    logic                 done;
    logic                 nack;
    eeprom_pkg::ee_data_t ee_rdata;
    eeprom_pkg::bit_op_t  op;
    eeprom_pkg::ee_data_t tx_byte;
    logic                 op_valid;
    logic                 op_ready;
    eeprom_pkg::ee_data_t rx_byte;
    logic                 ack_seen;

    eeprom_regs regs0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bresp     (bresp),
        .bready    (bready),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .rresp     (rresp),
        .rready    (rready),
        .cmd_write (cmd_write),
        .cmd_read  (cmd_read),
        .ee_addr   (ee_addr),
        .ee_wdata  (ee_wdata),
        .busy      (busy),
        .done      (done),
        .nack      (nack),
        .rdata_in  (ee_rdata)
    );

    eeprom_ctrl ctrl0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_write (cmd_write),
        .cmd_read  (cmd_read),
        .ee_addr   (ee_addr),
        .ee_wdata  (ee_wdata),
        .busy      (busy),
        .done      (done),
        .nack      (nack),
        .rdata_out (ee_rdata),
        .op        (op),
        .tx_byte   (tx_byte),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .rx_byte   (rx_byte),
        .ack_seen  (ack_seen)
    );

    i2c_bit_engine engine0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .op       (op),
        .tx_byte  (tx_byte),
        .op_valid (op_valid),
        .sda_in   (sda_in),
        .op_ready (op_ready),
        .rx_byte  (rx_byte),
        .ack_seen (ack_seen),
        .scl      (scl),
        .sda_oe   (sda_oe)
    );

endmodule

// ==== verilog/i2c_bit_engine.sv ====
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic                 CLK,
    input  logic                 RESET,
    input  eeprom_pkg::bit_op_t  op,
    input  eeprom_pkg::ee_data_t tx_byte,
    input  logic                 op_valid,
    input  logic                 sda_in,
    output logic                 op_ready,
    output eeprom_pkg::ee_data_t rx_byte,
    output logic                 ack_seen,
    output logic                 scl,
    output logic                 sda_oe
);
    eeprom_pkg::bit_op_t                         cur_op;
    eeprom_pkg::ee_data_t                        shift;
    logic                                        ack_bit;
    logic                                        active;
    logic [$clog2(2 * eeprom_pkg::scl_half)-1:0] step;
    logic [3:0]                                  bit_cnt;
    logic                                        cond_op;
    logic                                        last_step;
    logic                                        last_bit;
    logic                                        sample;

    assign op_ready  = !active;
    assign rx_byte   = shift;
    assign cond_op   = cur_op == eeprom_pkg::op_start || cur_op == eeprom_pkg::op_stop;
    assign last_step = step == 2 * eeprom_pkg::scl_half - 1;
    assign last_bit  = cond_op || bit_cnt == 4'd8;
    // middle of the visible SCL high phase
    assign sample    = step == eeprom_pkg::scl_half + eeprom_pkg::scl_half / 2;

    // every op is a low phase then a high phase, so SCL rests high between ops
    always_ff @(posedge CLK) begin
        if (RESET) begin
            active   <= 1'b0;
            cur_op   <= eeprom_pkg::op_stop;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
            ack_seen <= 1'b0;
            step     <= '0;
            bit_cnt  <= '0;
        end else if (!active) begin
            if (op_valid) begin
                active  <= 1'b1;
                cur_op  <= op;
                step    <= '0;
                bit_cnt <= '0;
            end
        end else begin
            if (cond_op) begin
                scl <= step >= eeprom_pkg::scl_half / 2;
                // sda flips late in the high phase, direction set by the op
                if (step != 0)
                    sda_oe <= (step >= eeprom_pkg::scl_half + 1) ^
                              (cur_op == eeprom_pkg::op_stop);
            end else begin
                scl <= step >= eeprom_pkg::scl_half;
                if (step == 1)  // one cycle after the falling edge
                    sda_oe <= bit_cnt == 4'd8 ? cur_op == eeprom_pkg::op_recv && !ack_bit
                                              : cur_op == eeprom_pkg::op_send && !shift[7];
                if (sample && bit_cnt == 4'd8 && cur_op == eeprom_pkg::op_send)
                    ack_seen <= !sda_in;
            end
            if (last_step) begin
                step    <= '0;
                bit_cnt <= bit_cnt + 4'd1;
                if (last_bit)
                    active <= 1'b0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (op_valid && op_ready) begin
            shift   <= tx_byte;
            ack_bit <= tx_byte[0];  // 1 means nack after recv
        end else if (active && !cond_op && bit_cnt < 4'd8) begin
            if (cur_op == eeprom_pkg::op_recv && sample)
                shift <= {shift[6:0], sda_in};
            if (cur_op == eeprom_pkg::op_send && last_step)
                shift <= {shift[6:0], 1'b0};
        end
    end

    assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_oe) |-> (!scl && !$past(scl)) || $past(active && cond_op))
        else $error("sda_oe moved while scl high outside start/stop");

endmodule
